/* simt_branch_top.f */
source/simt_branch_pkg.sv
source/warp_register_file.sv
source/branch_decoder.sv
source/branch_unit.sv
source/result_collector.sv
source/simt_branch_top.sv
bench/simt_branch_tb.sv

/* Bender.yml */
package:
  name: simt_branch

sources:
  # RTL in compile order
  - source/simt_branch_pkg.sv
  - source/warp_register_file.sv
  - source/branch_decoder.sv
  - source/branch_unit.sv
  - source/result_collector.sv
  - source/simt_branch_top.sv

  # Testbench
  - target: test
    files:
      - bench/simt_branch_tb.sv

/* bench/simt_branch_tb.sv */
// Testbench for the SIMT branch path
// Shadow register file, reference model, writeback and fetch report checks, watchdog
module simt_branch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import simt_branch_pkg::*;

    localparam int     n_bnz       = 24;
    localparam int     n_stream    = 64;
    localparam int     n_insts     = 4 + n_bnz + 2 + n_stream + 2;
    localparam longint watchdog_ns = (n_insts + 50) * 4 * 100;

    logic                       clk_i = 1'b0;
    logic                       reset_i;
    logic                       inst_valid_i;
    logic                       inst_ready_o;
    logic [inst_width-1:0]      inst_word_i;
    logic [pc_width-1:0]        inst_pc_i;
    logic [wid_width-1:0]       inst_wid_i;
    logic [warp_width-1:0]      inst_act_mask_i;
    logic                       wb_valid_o;
    logic                       wb_ready_i;
    logic [iid_width-1:0]       wb_iid_o;
    logic [reg_idx_width-1:0]   wb_dst_o;
    logic [warp_width-1:0]      wb_mask_o;
    logic [warp_data_width-1:0] wb_data_o;
    logic                       load_valid_i;
    logic [wid_width-1:0]       load_wid_i;
    logic [reg_idx_width-1:0]   load_idx_i;
    logic [warp_data_width-1:0] load_data_i;
    logic                       branch_o;
    logic [wid_width-1:0]       branch_wid_o;
    logic [warp_width-1:0]      branching_mask_o;
    logic [pc_width-1:0]        inactive_pc_o;

    // Expected writebacks, in issue order
    logic [iid_width-1:0]       exp_iid_q[$];
    logic [reg_idx_width-1:0]   exp_dst_q[$];
    logic [warp_width-1:0]      exp_mask_q[$];
    logic [warp_data_width-1:0] exp_data_q[$];
    // Expected fetch reports, BNZ only
    logic [wid_width-1:0]       fetch_wid_q[$];
    logic [warp_width-1:0]      fetch_mask_q[$];
    logic [pc_width-1:0]        fetch_pc_q[$];

    logic [tag_width-1:0]       tag_cnt [num_warps];
    logic [warp_data_width-1:0] shadow [num_warps][num_regs];
    logic [31:0]                rng;
    logic [31:0]                bp_state;
    logic                       bp_enable;
    int                         errors;
    int                         checks;
    int                         test_base;

    simt_branch_top dut (.*);

    always #50 clk_i = ~clk_i;

    // ####################
    // Helpers
    // ####################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [inst_width-1:0] make_jmp(input logic [2:0] dst);
        return {2'b00, dst, 11'b0};
    endfunction

    function automatic logic [inst_width-1:0] make_bnz(input logic [2:0] cond, input logic [2:0] dst);
        return {2'b01, cond, dst, 8'b0};
    endfunction

    // Expected result and fetch report, decoded straight from the word layout
    function automatic void ref_model(
        input  logic [inst_width-1:0]       word,
        input  logic [pc_width-1:0]         pc,
        input  logic [wid_width-1:0]        wid,
        input  logic [warp_width-1:0]       mask,
        output logic [reg_idx_width-1:0]    dst,
        output logic [warp_data_width-1:0]  data,
        output logic                        is_bnz,
        output logic [warp_width-1:0]       br_mask,
        output logic [pc_width-1:0]         next_pc
    );
        logic [reg_idx_width-1:0] cond_idx;
        logic [reg_width-1:0]     cond_val;
        is_bnz   = (word[15:14] == 2'd1);
        cond_idx = word[13:11];
        dst      = is_bnz ? word[10:8] : word[13:11];
        br_mask  = '0;
        for (int t = 0; t < warp_width; t++) begin
            cond_val = shadow[wid][cond_idx][t*reg_width +: reg_width];
            if (is_bnz) begin
                data[t*reg_width +: reg_width] = (cond_val != 0) ? 16'd1 : 16'd0;
                br_mask[t] = mask[t] && (cond_val != 0);
            end else begin
                data[t*reg_width +: reg_width] = {4'b0, pc};
            end
        end
        // 12-bit result wraps past 4095
        next_pc = pc + 1'b1;
    endfunction

    // Queue the expectation, then hold valid until the handshake
    task automatic send_inst(input logic [inst_width-1:0] word, input logic [pc_width-1:0] pc,
                             input logic [wid_width-1:0] wid, input logic [warp_width-1:0] mask);
        logic [reg_idx_width-1:0]   dst;
        logic [warp_data_width-1:0] data;
        logic                       is_bnz;
        logic [warp_width-1:0]      br_mask;
        logic [pc_width-1:0]        next_pc;
        logic                       done;
        ref_model(word, pc, wid, mask, dst, data, is_bnz, br_mask, next_pc);
        exp_iid_q.push_back({tag_cnt[wid], wid});
        exp_dst_q.push_back(dst);
        exp_mask_q.push_back(mask);
        exp_data_q.push_back(data);
        if (is_bnz) begin
            fetch_wid_q.push_back(wid);
            fetch_mask_q.push_back(br_mask);
            fetch_pc_q.push_back(next_pc);
        end
        tag_cnt[wid] = tag_cnt[wid] + 1'b1;
        inst_valid_i    = 1'b1;
        inst_word_i     = word;
        inst_pc_i       = pc;
        inst_wid_i      = wid;
        inst_act_mask_i = mask;
        do begin
            @(negedge clk_i);
            done = inst_ready_o;
            @(posedge clk_i);
            #10;
        end while (!done);
        inst_valid_i = 1'b0;
    endtask

    task automatic load_reg(input logic [wid_width-1:0] wid, input logic [reg_idx_width-1:0] idx,
                            input logic [warp_data_width-1:0] data);
        load_valid_i = 1'b1;
        load_wid_i   = wid;
        load_idx_i   = idx;
        load_data_i  = data;
        shadow[wid][idx] = data;
        @(posedge clk_i);
        #10;
        load_valid_i = 1'b0;
    endtask

    // Drain everything still expected
    task automatic wait_idle();
        while (exp_iid_q.size() != 0 || fetch_pc_q.size() != 0) begin
            @(posedge clk_i);
            #10;
        end
    endtask

    // Idle pipeline, wb_ready_i high
    task automatic check_latency(input logic [inst_width-1:0] word, input logic [pc_width-1:0] pc);
        logic is_bnz;
        is_bnz = (word[15:14] == 2'd1);
        send_inst(word, pc, 2'd3, 4'b1111);
        for (int k = 1; k <= 3; k++) begin
            @(negedge clk_i);
            checks++;
            assert (wb_valid_o == (k == 3)) else begin
                $display("error at %0d ns: wb_valid_o %b at cycle %0d after accept",
                         $time, wb_valid_o, k);
                errors++;
            end
            assert (branch_o == (is_bnz && k == 2)) else begin
                $display("error at %0d ns: branch_o %b at cycle %0d after accept",
                         $time, branch_o, k);
                errors++;
            end
        end
        @(posedge clk_i);
        #10;
        wait_idle();
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // ####################
    // Checkers
    // ####################

    // Random back-pressure only while enabled
    always @(posedge clk_i) begin
        #10;
        if (bp_enable) begin
            bp_state   = xorshift(bp_state);
            wb_ready_i = bp_state[3];
        end else begin
            wb_ready_i = 1'b1;
        end
    end

    always @(negedge clk_i) begin : compare_wb
        logic [iid_width-1:0]       e_iid;
        logic [reg_idx_width-1:0]   e_dst;
        logic [warp_width-1:0]      e_mask;
        logic [warp_data_width-1:0] e_data;
        if (!reset_i && wb_valid_o && wb_ready_i) begin
            if (exp_iid_q.size() == 0) begin
                $display("writeback at %0d ns with no instruction outstanding", $time);
                errors++;
            end else begin
                e_iid  = exp_iid_q.pop_front();
                e_dst  = exp_dst_q.pop_front();
                e_mask = exp_mask_q.pop_front();
                e_data = exp_data_q.pop_front();
                checks++;
                assert (wb_iid_o == e_iid) else begin
                    $display("error at %0d ns: iid %h, expected %h", $time, wb_iid_o, e_iid);
                    errors++;
                end
                assert (wb_dst_o == e_dst && wb_mask_o == e_mask) else begin
                    $display("error at %0d ns: dst %0d mask %b, expected %0d %b",
                             $time, wb_dst_o, wb_mask_o, e_dst, e_mask);
                    errors++;
                end
                assert (wb_data_o == e_data) else begin
                    $display("error at %0d ns: data %h, expected %h", $time, wb_data_o, e_data);
                    errors++;
                end
                // Shadow merge, active threads only
                for (int t = 0; t < warp_width; t++) begin
                    if (e_mask[t]) begin
                        shadow[e_iid[wid_width-1:0]][e_dst][t*reg_width +: reg_width] =
                            e_data[t*reg_width +: reg_width];
                    end
                end
            end
        end
    end

    always @(negedge clk_i) begin : compare_fetch
        logic [wid_width-1:0]  e_wid;
        logic [warp_width-1:0] e_mask;
        logic [pc_width-1:0]   e_pc;
        if (!reset_i && branch_o) begin
            if (fetch_pc_q.size() == 0) begin
                $display("fetch strobe at %0d ns with no BNZ outstanding", $time);
                errors++;
            end else begin
                e_wid  = fetch_wid_q.pop_front();
                e_mask = fetch_mask_q.pop_front();
                e_pc   = fetch_pc_q.pop_front();
                checks++;
                assert (branch_wid_o == e_wid && branching_mask_o == e_mask
                        && inactive_pc_o == e_pc) else begin
                    $display("error at %0d ns: fetch wid %0d mask %b pc %h, expected %0d %b %h",
                             $time, branch_wid_o, branching_mask_o, inactive_pc_o,
                             e_wid, e_mask, e_pc);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("TESTS FAILED");
        $finish;
    end

    // ####################
    // Test sequence
    // ####################

    initial begin : main
        logic [warp_data_width-1:0] ld_data;
        logic [pc_width-1:0]        pc;
        reset_i         = 1'b1;
        inst_valid_i    = 1'b0;
        inst_word_i     = '0;
        inst_pc_i       = '0;
        inst_wid_i      = '0;
        inst_act_mask_i = '0;
        wb_ready_i      = 1'b1;
        load_valid_i    = 1'b0;
        load_wid_i      = '0;
        load_idx_i      = '0;
        load_data_i     = '0;
        bp_enable       = 1'b0;
        rng             = 32'd2;
        bp_state        = 32'd2;
        errors          = 0;
        checks          = 0;
        test_base       = 0;
        for (int w = 0; w < num_warps; w++) begin
            tag_cnt[w] = '0;
            for (int r = 0; r < num_regs; r++) begin
                shadow[w][r] = '0;
            end
        end
        repeat (5) @(posedge clk_i);
        #10;
        reset_i = 1'b0;

        // Test 1: reset state, first JMP per warp
        @(negedge clk_i);
        assert (!wb_valid_o && !branch_o && inst_ready_o) else begin
            $display("error at %0d ns: after reset wb_valid_o %b branch_o %b inst_ready_o %b",
                     $time, wb_valid_o, branch_o, inst_ready_o);
            errors++;
        end
        @(posedge clk_i);
        #10;
        for (int w = 0; w < num_warps; w++) begin
            send_inst(make_jmp(3'd4 + w), 12'h100 + 12'(w * 17), w, 4'b1111);
        end
        wait_idle();
        report_test("test 1 reset and first JMP");

        // Test 2: condition regs 0..3, some threads zero
        for (int w = 0; w < num_warps; w++) begin
            for (int r = 0; r < 4; r++) begin
                for (int t = 0; t < warp_width; t++) begin
                    rng = xorshift(rng);
                    ld_data[t*reg_width +: reg_width] = (rng[1:0] == 2'd0) ? '0 : rng[31:16];
                end
                load_reg(w, r, ld_data);
            end
        end
        for (int i = 0; i < n_bnz; i++) begin
            rng = xorshift(rng);
            pc  = (i % 8 == 0) ? 12'hfff : rng[27:16];
            send_inst(make_bnz({1'b0, rng[1:0]}, {1'b1, rng[3:2]}), pc, rng[5:4], rng[9:6]);
        end
        wait_idle();
        report_test("test 2 BNZ flags and fetch report");

        // Test 3: partial JMP link read back by a BNZ
        load_reg(2'd1, 3'd5, '0);
        send_inst(make_jmp(3'd5), 12'h0a5, 2'd1, 4'b0101);
        wait_idle();
        send_inst(make_bnz(3'd5, 3'd6), 12'h0b0, 2'd1, 4'b1111);
        wait_idle();
        report_test("test 3 masked writeback");

        // Test 4: mixed stream under random back-pressure
        bp_enable = 1'b1;
        for (int i = 0; i < n_stream; i++) begin
            rng = xorshift(rng);
            if (rng[0]) begin
                send_inst(make_bnz({1'b0, rng[20:19]}, {1'b1, rng[22:21]}), rng[18:7],
                          rng[2:1], rng[6:3]);
            end else begin
                send_inst(make_jmp({1'b1, rng[22:21]}), rng[18:7], rng[2:1], rng[6:3]);
            end
        end
        wait_idle();
        bp_enable = 1'b0;
        report_test("test 4 back-pressure stream");

        // Test 5: latency with no stalls
        repeat (2) @(posedge clk_i);
        #10;
        check_latency(make_jmp(3'd7), 12'h3c0);
        check_latency(make_bnz(3'd2, 3'd7), 12'h3c1);
        report_test("test 5 latency");

        // Catch late or repeated writebacks
        repeat (4) @(posedge clk_i);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* source/simt_branch_top.sv */
// Branch path top level
// Decoder, register file, branch unit and result collector
module simt_branch_top (
    input  logic clk_i,
    input  logic reset_i,

    // Instruction in
    input  logic                                         inst_valid_i,
    output logic                                         inst_ready_o,
    input  logic [simt_branch_pkg::inst_width-1:0]       inst_word_i,
    input  logic [simt_branch_pkg::pc_width-1:0]         inst_pc_i,
    input  logic [simt_branch_pkg::wid_width-1:0]        inst_wid_i,
    input  logic [simt_branch_pkg::warp_width-1:0]       inst_act_mask_i,

    // Writeback out
    output logic                                         wb_valid_o,
    input  logic                                         wb_ready_i,
    output logic [simt_branch_pkg::iid_width-1:0]        wb_iid_o,
    output logic [simt_branch_pkg::reg_idx_width-1:0]    wb_dst_o,
    output logic [simt_branch_pkg::warp_width-1:0]       wb_mask_o,
    output logic [simt_branch_pkg::warp_data_width-1:0]  wb_data_o,

    // External register load
    input  logic                                         load_valid_i,
    input  logic [simt_branch_pkg::wid_width-1:0]        load_wid_i,
    input  logic [simt_branch_pkg::reg_idx_width-1:0]    load_idx_i,
    input  logic [simt_branch_pkg::warp_data_width-1:0]  load_data_i,

    // Fetch report
    output logic                                         branch_o,
    output logic [simt_branch_pkg::wid_width-1:0]        branch_wid_o,
    output logic [simt_branch_pkg::warp_width-1:0]       branching_mask_o,
    output logic [simt_branch_pkg::pc_width-1:0]         inactive_pc_o
);
    import simt_branch_pkg::*;

    // Register file read
    logic [wid_width-1:0]       rf_rwid;
    logic [reg_idx_width-1:0]   rf_ridx;
    logic [warp_data_width-1:0] rf_rdata;

    // Decoder to branch unit
    logic                       dec_valid;
    logic                       dec_ready;
    bru_subtype_e               dec_subtype;
    logic [iid_width-1:0]       dec_iid;
    logic [reg_idx_width-1:0]   dec_dst;
    logic [pc_width-1:0]        dec_pc;
    logic [warp_width-1:0]      dec_mask;
    logic [warp_data_width-1:0] dec_cond;

    // Branch unit to collector
    logic                       exe_valid;
    logic                       exe_ready;
    logic [iid_width-1:0]       exe_iid;
    logic [reg_idx_width-1:0]   exe_dst;
    logic [warp_width-1:0]      exe_mask;
    logic [warp_data_width-1:0] exe_data;

    // Collector to register file
    logic                       rf_we;
    logic [wid_width-1:0]       rf_wid;
    logic [reg_idx_width-1:0]   rf_idx;
    logic [warp_width-1:0]      rf_mask;
    logic [warp_data_width-1:0] rf_data;

    branch_decoder i_decoder (
        .clk_i, .reset_i,
        .inst_valid_i, .inst_ready_o, .inst_word_i, .inst_pc_i, .inst_wid_i, .inst_act_mask_i,
        .rf_rwid_o(rf_rwid), .rf_ridx_o(rf_ridx), .rf_rdata_i(rf_rdata),
        .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_subtype_o(dec_subtype),
        .dec_iid_o(dec_iid), .dec_dst_o(dec_dst), .dec_pc_o(dec_pc),
        .dec_mask_o(dec_mask), .dec_cond_o(dec_cond)
    );

    warp_register_file i_regfile (
        .clk_i, .reset_i,
        .rf_rwid_i(rf_rwid), .rf_ridx_i(rf_ridx), .rf_rdata_o(rf_rdata),
        .rf_we_i(rf_we), .rf_wid_i(rf_wid), .rf_idx_i(rf_idx),
        .rf_mask_i(rf_mask), .rf_data_i(rf_data),
        .load_valid_i, .load_wid_i, .load_idx_i, .load_data_i
    );

    branch_unit i_branch_unit (
        .clk_i, .reset_i,
        .dec_valid_i(dec_valid), .dec_ready_o(dec_ready), .dec_subtype_i(dec_subtype),
        .dec_iid_i(dec_iid), .dec_dst_i(dec_dst), .dec_pc_i(dec_pc),
        .dec_mask_i(dec_mask), .dec_cond_i(dec_cond),
        .exe_valid_o(exe_valid), .exe_ready_i(exe_ready), .exe_iid_o(exe_iid),
        .exe_dst_o(exe_dst), .exe_mask_o(exe_mask), .exe_data_o(exe_data),
        .branch_o, .branch_wid_o, .branching_mask_o, .inactive_pc_o
    );

    result_collector i_collector (
        .clk_i, .reset_i,
        .exe_valid_i(exe_valid), .exe_ready_o(exe_ready), .exe_iid_i(exe_iid),
        .exe_dst_i(exe_dst), .exe_mask_i(exe_mask), .exe_data_i(exe_data),
        .wb_valid_o, .wb_ready_i, .wb_iid_o, .wb_dst_o, .wb_mask_o, .wb_data_o,
        .rf_we_o(rf_we), .rf_wid_o(rf_wid), .rf_idx_o(rf_idx),
        .rf_mask_o(rf_mask), .rf_data_o(rf_data)
    );

endmodule

/* source/result_collector.sv */
// Result collector
// Holds one result under back-pressure, commits it to the register file on accept
module result_collector (
    input  logic clk_i,
    input  logic reset_i,

    // From branch unit
    input  logic                                         exe_valid_i,
    output logic                                         exe_ready_o,
    input  logic [simt_branch_pkg::iid_width-1:0]        exe_iid_i,
    input  logic [simt_branch_pkg::reg_idx_width-1:0]    exe_dst_i,
    input  logic [simt_branch_pkg::warp_width-1:0]       exe_mask_i,
    input  logic [simt_branch_pkg::warp_data_width-1:0]  exe_data_i,

    // Writeback out
    output logic                                         wb_valid_o,
    input  logic                                         wb_ready_i,
    output logic [simt_branch_pkg::iid_width-1:0]        wb_iid_o,
    output logic [simt_branch_pkg::reg_idx_width-1:0]    wb_dst_o,
    output logic [simt_branch_pkg::warp_width-1:0]       wb_mask_o,
    output logic [simt_branch_pkg::warp_data_width-1:0]  wb_data_o,

    // Register file write
    output logic                                         rf_we_o,
    output logic [simt_branch_pkg::wid_width-1:0]        rf_wid_o,
    output logic [simt_branch_pkg::reg_idx_width-1:0]    rf_idx_o,
    output logic [simt_branch_pkg::warp_width-1:0]       rf_mask_o,
    output logic [simt_branch_pkg::warp_data_width-1:0]  rf_data_o
);
    import simt_branch_pkg::*;

    logic accept;

    assign exe_ready_o = wb_ready_i || !wb_valid_o;
    assign accept      = exe_valid_i && exe_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else if (accept) begin
            wb_valid_o <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_iid_o  <= exe_iid_i;
            wb_dst_o  <= exe_dst_i;
            wb_mask_o <= exe_mask_i;
            wb_data_o <= exe_data_i;
        end
    end

    // Commit in the writeback transfer cycle, warp ID from the iid low bits
    assign rf_we_o   = wb_valid_o && wb_ready_i;
    assign rf_wid_o  = wb_iid_o[wid_width-1:0];
    assign rf_idx_o  = wb_dst_o;
    assign rf_mask_o = wb_mask_o;
    assign rf_data_o = wb_data_o;

    // Held result stays put until taken
    assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_valid_o && !wb_ready_i) |=> wb_valid_o && $stable(wb_iid_o) && $stable(wb_data_o))
        else $error("writeback changed while stalled");

endmodule

/* source/branch_unit.sv */
// Branch execute stage
// JMP link and BNZ flag results, registered fetch report, output pipeline register
module branch_unit (
    input  logic clk_i,
    input  logic reset_i,

    // From decoder
    input  logic                                         dec_valid_i,
    output logic                                         dec_ready_o,
    input  simt_branch_pkg::bru_subtype_e                dec_subtype_i,
    input  logic [simt_branch_pkg::iid_width-1:0]        dec_iid_i,
    input  logic [simt_branch_pkg::reg_idx_width-1:0]    dec_dst_i,
    input  logic [simt_branch_pkg::pc_width-1:0]         dec_pc_i,
    input  logic [simt_branch_pkg::warp_width-1:0]       dec_mask_i,
    input  logic [simt_branch_pkg::warp_data_width-1:0]  dec_cond_i,

    // To result collector
    output logic                                         exe_valid_o,
    input  logic                                         exe_ready_i,
    output logic [simt_branch_pkg::iid_width-1:0]        exe_iid_o,
    output logic [simt_branch_pkg::reg_idx_width-1:0]    exe_dst_o,
    output logic [simt_branch_pkg::warp_width-1:0]       exe_mask_o,
    output logic [simt_branch_pkg::warp_data_width-1:0]  exe_data_o,

    // Divergence report to fetch
    output logic                                         branch_o,
    output logic [simt_branch_pkg::wid_width-1:0]        branch_wid_o,
    output logic [simt_branch_pkg::warp_width-1:0]       branching_mask_o,
    output logic [simt_branch_pkg::pc_width-1:0]         inactive_pc_o
);
    import simt_branch_pkg::*;

    logic [warp_data_width-1:0] result;
    logic [warp_width-1:0]      cond_nz;
    logic                       accept;
    logic                       bnz_accept;

    // ####################
    // Result per thread
    // ####################

    always_comb begin
        for (int t = 0; t < warp_width; t++) begin
            cond_nz[t] = dec_cond_i[t*reg_width +: reg_width] != '0;
            case (dec_subtype_i)
                // Link value is the branch PC itself
                bru_jmp: result[t*reg_width +: reg_width] =
                    {{(reg_width-pc_width){1'b0}}, dec_pc_i};
                // Flag is 0 or 1
                bru_bnz: result[t*reg_width +: reg_width] =
                    {{(reg_width-1){1'b0}}, cond_nz[t]};
                default: result[t*reg_width +: reg_width] = '0;
            endcase
        end
    end

    assign dec_ready_o = exe_ready_i || !exe_valid_o;
    assign accept      = dec_valid_i && dec_ready_o;
    assign bnz_accept  = accept && (dec_subtype_i == bru_bnz);

    // ####################
    // Fetch report
    // ####################

    // One strobe per BNZ transfer, never on a stall
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            branch_o         <= 1'b0;
            branching_mask_o <= '0;
        end else begin
            branch_o         <= bnz_accept;
            branching_mask_o <= bnz_accept ? (dec_mask_i & cond_nz) : '0;
        end
    end

    // Fall-through PC wraps in 12 bits
    always_ff @(posedge clk_i) begin
        if (bnz_accept) begin
            branch_wid_o  <= dec_iid_i[wid_width-1:0];
            inactive_pc_o <= dec_pc_i + 1'b1;
        end
    end

    // ####################
    // Pipeline register
    // ####################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exe_valid_o <= 1'b0;
        end else if (accept) begin
            exe_valid_o <= 1'b1;
        end else if (exe_ready_i) begin
            exe_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            exe_iid_o  <= dec_iid_i;
            exe_dst_o  <= dec_dst_i;
            exe_mask_o <= dec_mask_i;
            exe_data_o <= result;
        end
    end

    // Back-to-back strobes belong to two different instructions
    assert property (@(posedge clk_i) disable iff (reset_i)
        (branch_o && $past(branch_o)) |-> (exe_iid_o != $past(exe_iid_o)))
        else $error("branch strobe repeated for one instruction");

endmodule

/* source/branch_decoder.sv */
// Branch decoder stage
// Word decode, per-warp tag counters, condition operand read, pipeline register
module branch_decoder (
    input  logic clk_i,
    input  logic reset_i,

    // Instruction from issue
    input  logic                                         inst_valid_i,
    output logic                                         inst_ready_o,
    input  logic [simt_branch_pkg::inst_width-1:0]       inst_word_i,
    input  logic [simt_branch_pkg::pc_width-1:0]         inst_pc_i,
    input  logic [simt_branch_pkg::wid_width-1:0]        inst_wid_i,
    input  logic [simt_branch_pkg::warp_width-1:0]       inst_act_mask_i,

    // Register file read port
    output logic [simt_branch_pkg::wid_width-1:0]        rf_rwid_o,
    output logic [simt_branch_pkg::reg_idx_width-1:0]    rf_ridx_o,
    input  logic [simt_branch_pkg::warp_data_width-1:0]  rf_rdata_i,

    // To branch unit
    output logic                                         dec_valid_o,
    input  logic                                         dec_ready_i,
    output simt_branch_pkg::bru_subtype_e                dec_subtype_o,
    output logic [simt_branch_pkg::iid_width-1:0]        dec_iid_o,
    output logic [simt_branch_pkg::reg_idx_width-1:0]    dec_dst_o,
    output logic [simt_branch_pkg::pc_width-1:0]         dec_pc_o,
    output logic [simt_branch_pkg::warp_width-1:0]       dec_mask_o,
    output logic [simt_branch_pkg::warp_data_width-1:0]  dec_cond_o
);
    import simt_branch_pkg::*;

    branch_inst_u             inst;
    bru_subtype_e             inst_subtype;
    logic [reg_idx_width-1:0] inst_dst;
    logic [tag_width-1:0]     tag_q [num_warps];
    logic                     accept;

    // ####################
    // Decode
    // ####################

    assign inst = inst_word_i;

    // Subtype sits in the same bits for both views
    assign inst_subtype = inst.jmp_fmt.subtype;
    assign inst_dst     = (inst_subtype == bru_bnz) ? inst.bnz_fmt.dst : inst.jmp_fmt.dst;

    // Condition operand, harmless read for JMP
    assign rf_rwid_o = inst_wid_i;
    assign rf_ridx_o = inst.bnz_fmt.cond;

    // Stage free when empty or draining this cycle
    assign inst_ready_o = dec_ready_i || !dec_valid_o;
    assign accept       = inst_valid_i && inst_ready_o;

    // Tag counters, wrap at num_tags
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < num_warps; w++) begin
                tag_q[w] <= '0;
            end
        end else if (accept) begin
            tag_q[inst_wid_i] <= tag_q[inst_wid_i] + 1'b1;
        end
    end

    // ####################
    // Pipeline register
    // ####################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else if (accept) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_subtype_o <= inst_subtype;
            dec_iid_o     <= {tag_q[inst_wid_i], inst_wid_i};
            dec_dst_o     <= inst_dst;
            dec_pc_o      <= inst_pc_i;
            dec_mask_o    <= inst_act_mask_i;
            dec_cond_o    <= rf_rdata_i;
        end
    end

    // Only JMP and BNZ ever reach the branch unit
    assert property (@(posedge clk_i) disable iff (reset_i)
        accept |=> dec_valid_o && (dec_subtype_o inside {bru_jmp, bru_bnz}))
        else $error("invalid branch subtype accepted");

endmodule

/* source/warp_register_file.sv */
// Per-warp register storage
// Combinational read, thread-masked writeback, full-width load port
module warp_register_file (
    input  logic clk_i,
    input  logic reset_i,

    // Decoder read
    input  logic [simt_branch_pkg::wid_width-1:0]        rf_rwid_i,
    input  logic [simt_branch_pkg::reg_idx_width-1:0]    rf_ridx_i,
    output logic [simt_branch_pkg::warp_data_width-1:0]  rf_rdata_o,

    // Writeback from result collector
    input  logic                                         rf_we_i,
    input  logic [simt_branch_pkg::wid_width-1:0]        rf_wid_i,
    input  logic [simt_branch_pkg::reg_idx_width-1:0]    rf_idx_i,
    input  logic [simt_branch_pkg::warp_width-1:0]       rf_mask_i,
    input  logic [simt_branch_pkg::warp_data_width-1:0]  rf_data_i,

    // External load
    input  logic                                         load_valid_i,
    input  logic [simt_branch_pkg::wid_width-1:0]        load_wid_i,
    input  logic [simt_branch_pkg::reg_idx_width-1:0]    load_idx_i,
    input  logic [simt_branch_pkg::warp_data_width-1:0]  load_data_i
);
    import simt_branch_pkg::*;

    logic [warp_data_width-1:0] regs_q [num_warps][num_regs];

    assign rf_rdata_o = regs_q[rf_rwid_i][rf_ridx_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < num_warps; w++) begin
                for (int r = 0; r < num_regs; r++) begin
                    regs_q[w][r] <= '0;
                end
            end
        end else begin
            // Writeback merges per thread
            if (rf_we_i) begin
                for (int t = 0; t < warp_width; t++) begin
                    if (rf_mask_i[t]) begin
                        regs_q[rf_wid_i][rf_idx_i][t*reg_width +: reg_width] <=
                            rf_data_i[t*reg_width +: reg_width];
                    end
                end
            end
            // Load comes last so it wins
            if (load_valid_i) begin
                regs_q[load_wid_i][load_idx_i] <= load_data_i;
            end
        end
    end

    // Load and writeback on one register lose the writeback
    assert property (@(posedge clk_i) disable iff (reset_i)
        !(load_valid_i && rf_we_i && (load_wid_i == rf_wid_i) && (load_idx_i == rf_idx_i)))
        else $error("load and writeback collide on warp %0d reg %0d", rf_wid_i, rf_idx_i);

endmodule

/* source/simt_branch_pkg.sv */
// Shared sizes for the SIMT branch path
// Branch subtype encoding and the two views of a branch instruction word
package simt_branch_pkg;

    // ####################
    // Warp and register sizes
    // ####################

    // Threads per warp and bits per thread register
    localparam int unsigned warp_width = 4;
    localparam int unsigned reg_width  = 16;

    // Warps and their ID width
    localparam int unsigned num_warps = 4;
    localparam int unsigned wid_width = $clog2(num_warps);

    // In-flight tags per warp
    localparam int unsigned num_tags  = 4;
    localparam int unsigned tag_width = $clog2(num_tags);

    // Instruction ID is {tag, wid}
    localparam int unsigned iid_width = tag_width + wid_width;

    // Registers per warp
    localparam int unsigned reg_idx_width = 3;
    localparam int unsigned num_regs      = 2 ** reg_idx_width;

    localparam int unsigned pc_width   = 12;
    localparam int unsigned inst_width = 16;

    // One register across all threads, thread i in slice i
    localparam int unsigned warp_data_width = warp_width * reg_width;

    // ####################
    // Instruction encoding
    // ####################

    // Codes 2 and 3 are both invalid
    typedef enum logic [1:0] {
        bru_jmp     = 2'd0,
        bru_bnz     = 2'd1,
        bru_invalid = 2'd2
    } bru_subtype_e;

    // JMP: link destination right below the subtype
    typedef struct packed {
        bru_subtype_e             subtype;
        logic [reg_idx_width-1:0] dst;
        logic [10:0]              rsvd;
    } jmp_fmt_t;

    // BNZ: condition register first, then the flag destination
    typedef struct packed {
        bru_subtype_e             subtype;
        logic [reg_idx_width-1:0] cond;
        logic [reg_idx_width-1:0] dst;
        logic [7:0]               rsvd;
    } bnz_fmt_t;

    // Destination field moves with the subtype
    typedef union packed {
        jmp_fmt_t jmp_fmt;
        bnz_fmt_t bnz_fmt;
    } branch_inst_u;

endpackage
